// ==== dv/pathSeedTb.sv ====
// Testbench for pathSeedTop with reference model and scoreboard
// Steady, paired, back-pressure, reset and fill tests plus timeout

`default_nettype none

module pathSeedTb import oramPkg::*;;

	localparam int PathLen = OramLevels + 1;
	localparam int ResetCycles = 4;
	// About 700 transfers at half ready plus margin
	localparam int CycleLimit = 4000;

	logic   Clock;
	logic   rstN;
	logic   padReady;
	padT    pad;
	logic   padValid;

	integer seed;
	integer randWord;
	string  testName;
	int     expIdx = 0;
	int     outCount = 0;
	int     genCount = 0;
	int     cycleCount = 0;
	int     errorCount = 0;
	int     testBase;
	int     testErrors;
	int     testsRun = 0;
	int     testsFailed = 0;
	int     target;
	int     totalErrors;
	padT    expItem;
	seedT   readSeed;

	pathSeedTop dut (
		.Clock    (Clock),
		.rstN     (rstN),
		.pad      (pad),
		.padValid (padValid),
		.padReady (padReady)
	);

	initial begin
		Clock = 1'b0;
		forever #10 Clock = ~Clock;
	end

	// ----------------------------------------------------------------------
	// Reference model
	// ----------------------------------------------------------------------

	// Seed number idx counted from reset with 10 per path
	function automatic seedT expectedSeed(input int idx);
		int                    passNum;
		int                    lvl;
		logic [IvWidth-1:0]    c;
		logic [OramLevels-1:0] leaf;
		seedT                  item;
		c = IvWidth'(idx / (2 * PathLen));
		passNum = (idx / PathLen) % 2;
		lvl = idx % PathLen;
		leaf = c[OramLevels-1:0];
		item.iv = (c >> lvl) + IvWidth'(passNum);
		item.bid = BidWidth'((1 << lvl) - 1 + (leaf >> (OramLevels - lvl)));
		item.write = (passNum == 1);
		return item;
	endfunction

	// Keyed add and rotate on the model seed
	function automatic padT expectedPad(input int idx);
		seedT                 seedItem;
		logic [IvWidth-1:0]   word;
		logic [2*IvWidth-1:0] doubled;
		padT                  item;
		seedItem = expectedSeed(idx);
		word = (seedItem.iv ^ MixKey) + IvWidth'(seedItem.bid);
		// Upper half of the doubled word is the left rotate
		doubled = {word, word} << MixRotate;
		item.pad = doubled[2*IvWidth-1:IvWidth] ^ seedItem.iv;
		item.bid = seedItem.bid;
		item.write = seedItem.write;
		return item;
	endfunction

	// ----------------------------------------------------------------------
	// Scoreboard and monitors
	// ----------------------------------------------------------------------

	always @(posedge Clock) begin
		if (!rstN) begin
			expIdx <= 0;
		end else if (padValid && padReady) begin
			expItem = expectedPad(expIdx);
			assert (pad == expItem) else begin
				$display("[FAIL] %s: expected %h actual %h", testName, expItem, pad);
				errorCount++;
			end
			expIdx   <= expIdx + 1;
			outCount <= outCount + 1;
		end
	end

	// Write pass repeats the model read pass bids with the IV one higher
	always @(posedge Clock) begin
		if (!rstN) begin
			genCount <= 0;
		end else if (dut.genValid && dut.genReady) begin
			if (((genCount / PathLen) % 2) == 1) begin
				readSeed = expectedSeed(genCount - PathLen);
				assert (dut.genSeed.iv == readSeed.iv + 1) else begin
					$display("[FAIL] %s: expected iv %h actual %h", testName,
						readSeed.iv + 1, dut.genSeed.iv);
					errorCount++;
				end
				assert (dut.genSeed.bid == readSeed.bid) else begin
					$display("[FAIL] %s: expected bid %h actual %h", testName,
						readSeed.bid, dut.genSeed.bid);
					errorCount++;
				end
			end
			genCount <= genCount + 1;
		end
	end

	always @(posedge Clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CycleLimit) begin
			$display("Run stalled, still running after %0d cycles", CycleLimit);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// ----------------------------------------------------------------------
	// Helpers
	// ----------------------------------------------------------------------

	task automatic applyReset();
		@(posedge Clock);
		rstN <= 1'b0;
		repeat (ResetCycles) @(posedge Clock);
		rstN <= 1'b1;
	endtask

	task automatic waitOutputs(input int count);
		target = outCount + count;
		while (outCount < target) @(posedge Clock);
	endtask

	task automatic startTest(input string name);
		testName = name;
		testBase = errorCount + dut.chk.failCount;
	endtask

	task automatic endTest();
		testErrors = errorCount + dut.chk.failCount - testBase;
		testsRun++;
		if (testErrors != 0) begin
			testsFailed++;
		end
		$display("Test %s finished with %0d errors", testName, testErrors);
	endtask

	// ----------------------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------------------

	initial begin
		rstN = 1'b0;
		padReady = 1'b0;
		seed = 32'h6967039a;
		testName = "reset";
		applyReset();

		startTest("steadyStream");
		padReady <= 1'b1;
		waitOutputs(32 * 2 * PathLen);
		endTest();

		// Ten more paths while the pairing monitor runs
		startTest("rwPairing");
		waitOutputs(10 * 2 * PathLen);
		endTest();

		startTest("randomBackpressure");
		target = outCount + 200;
		while (outCount < target) begin
			@(posedge Clock);
			randWord = $random(seed);
			padReady <= randWord[0];
		end
		@(posedge Clock);
		padReady <= 1'b1;
		endTest();

		// Wait for the output to sit inside a write pass
		startTest("resetMidStream");
		while ((expIdx % (2 * PathLen)) < PathLen + 2) @(posedge Clock);
		applyReset();
		waitOutputs(2 * 2 * PathLen);
		endTest();

		// Back-pressure until the generator sees a full seed FIFO
		startTest("pipelineFill");
		applyReset();
		padReady <= 1'b0;
		while (dut.genReady) @(posedge Clock);
		@(posedge Clock);
		padReady <= 1'b1;
		waitOutputs(3 * 2 * PathLen);
		endTest();

		@(posedge Clock);
		totalErrors = errorCount + dut.chk.failCount;
		$display("Tests run %0d, tests failed %0d, outputs checked %0d, errors %0d",
			testsRun, testsFailed, outCount, totalErrors);
		if (totalErrors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/pathSeed_chk.sv ====
// Concurrent protocol assertions for the path seed chain
// Bound into pathSeedTop at the end of this file

`default_nettype none

module pathSeedChk import oramPkg::*; (
	input wire logic Clock,
	input wire logic rstN,
	input wire padT  pad,
	input wire logic padValid,
	input wire logic padReady,
	input wire logic genValid,
	input wire logic bufValid,
	input wire logic bufReady,
	input wire logic mixValid,
	input wire logic mixReady
);

	// Failures seen so far, read by the testbench at the end
	int   failCount = 0;
	// Reset already seen on the previous edge
	logic inResetPrev;

	always_ff @(posedge Clock) begin
		inResetPrev <= !rstN;
	end

	// ----------------------------------------------------------------------
	// Output side
	// ----------------------------------------------------------------------

	// FIFO count clears on the first reset edge
	assert property (@(posedge Clock) (!rstN && inResetPrev) |-> !padValid)
	else begin
		$error("padValid high during reset");
		failCount = failCount + 1;
	end

	// Stalled output holds its payload
	assert property (@(posedge Clock) disable iff (!rstN)
		(padValid && !padReady) |=> (padValid && $stable(pad)))
	else begin
		$error("pad changed or dropped while stalled");
		failCount = failCount + 1;
	end

	// ----------------------------------------------------------------------
	// Generator and mixer
	// ----------------------------------------------------------------------

	// Generator never withdraws an offer
	assert property (@(posedge Clock) disable iff (!rstN) genValid |=> genValid)
	else begin
		$error("seedValid dropped after start");
		failCount = failCount + 1;
	end

	// Input transfer, then stage two free a cycle later
	assert property (@(posedge Clock) disable iff (!rstN)
		((bufValid && bufReady) ##1 (!mixValid || mixReady)) |=> mixValid)
	else begin
		$error("mixer output not valid 2 cycles after input transfer");
		failCount = failCount + 1;
	end

endmodule

bind pathSeedTop pathSeedChk chk (
	.Clock    (Clock),
	.rstN     (rstN),
	.pad      (pad),
	.padValid (padValid),
	.padReady (padReady),
	.genValid (genValid),
	.bufValid (bufValid),
	.bufReady (bufReady),
	.mixValid (mixValid),
	.mixReady (mixReady)
);

`default_nettype wire

// ==== hdl/bucketIndexGen.sv ====
// Heap index walker for one root-to-leaf path
// Steps one level per advance and reloads the leaf on restart

`default_nettype none

module bucketIndexGen import oramPkg::*; (
	input  logic                  Clock,
	input  logic                  rstN,
	input  logic                  restart,
	input  logic [OramLevels-1:0] leaf,
	input  logic                  advance,
	output logic [BidWidth-1:0]   bucketIndex
);

	// Current depth, root is level 0
	logic [LevelWidth-1:0] level;
	// Leaf bits still to be consumed, MSB first
	logic [OramLevels-1:0] leafShift;
	// Heap index of the bucket at the current level
	logic [BidWidth-1:0]   indexReg;
	logic                  stepDown;

	// No stepping past the leaf
	assign stepDown = advance && (level != LevelWidth'(OramLevels));

	// ----------------------------------------------------------------------
	// Level and index state
	// ----------------------------------------------------------------------

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			level    <= '0;
			indexReg <= '0;
		end else if (restart) begin
			// Back to the root, heap index 0
			level    <= '0;
			indexReg <= '0;
		end else if (stepDown) begin
			level <= level + LevelWidth'(1);
			// Child of i is 2i+1 (left) or 2i+2 (right)
			indexReg <= (indexReg << 1) + BidWidth'(1)
				+ BidWidth'(leafShift[OramLevels-1]);
		end
	end

	// Leaf copy, next branch bit always in the MSB
	always_ff @(posedge Clock) begin
		if (restart) begin
			leafShift <= leaf;
		end else if (stepDown) begin
			leafShift <= {leafShift[OramLevels-2:0], 1'b0};
		end
	end

	// Ready as soon as the level is entered
	assign bucketIndex = indexReg;

endmodule

`default_nettype wire

// ==== hdl/oramPkg.sv ====
// Shared tree-size constants, mixing key and rotate amount
// Seed and pad payload structs for the path seed chain

`default_nettype none

package oramPkg;

	// ----------------------------------------------------------------------
	// Tree geometry
	// ----------------------------------------------------------------------

	// Levels below the root, 16 leaves
	localparam int OramLevels = 4;
	// Heap index of any bucket in the tree
	localparam int BidWidth = OramLevels + 1;
	// Enough to count OramLevels+1 buckets of a path
	localparam int LevelWidth = $clog2(OramLevels + 1);

	// ----------------------------------------------------------------------
	// Seed and mixing
	// ----------------------------------------------------------------------

	localparam int IvWidth = 32;
	localparam int FifoDepth = 4;
	// Stand-in for the AES key
	localparam logic [IvWidth-1:0] MixKey = 32'h5a3c96e1;
	localparam int MixRotate = 13;

	// One bucket seed, 38 bits
	typedef struct packed {
		logic [IvWidth-1:0]  iv;
		logic [BidWidth-1:0] bid;
		logic                write;
	} seedT;

	// Mixed pad with its bucket tag
	typedef struct packed {
		logic [IvWidth-1:0]  pad;
		logic [BidWidth-1:0] bid;
		logic                write;
	} padT;

endpackage

`default_nettype wire

// ==== hdl/padMixer.sv ====
// Two-stage keyed mixing pipeline, seed in and pad out
// Stage one XOR key plus index, stage two rotate and XOR with IV

`default_nettype none

module padMixer import oramPkg::*; (
	input  logic Clock,
	input  logic rstN,
	input  seedT seed,
	input  logic seedValid,
	output logic seedReady,
	output padT  pad,
	output logic padValid,
	input  logic padReady
);

	// Stage one register contents
	typedef struct packed {
		logic [IvWidth-1:0]  word;
		logic [IvWidth-1:0]  iv;
		logic [BidWidth-1:0] bid;
		logic                write;
	} mixStageT;

	mixStageT           s1Data;
	logic               s1Valid;
	padT                s2Data;
	logic               s2Valid;
	logic               s1Advance;
	logic               s2Advance;
	logic [IvWidth-1:0] rotWord;

	// ----------------------------------------------------------------------
	// Stall control
	// ----------------------------------------------------------------------

	// A stage loads when its successor is empty or draining
	assign s2Advance = !s2Valid || padReady;
	assign s1Advance = !s1Valid || s2Advance;
	assign seedReady = s1Advance;

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			s1Valid <= 1'b0;
			s2Valid <= 1'b0;
		end else begin
			if (s1Advance) begin
				s1Valid <= seedValid;
			end
			if (s2Advance) begin
				s2Valid <= s1Valid;
			end
		end
	end

	// ----------------------------------------------------------------------
	// Stage one, keyed add
	// ----------------------------------------------------------------------

	always_ff @(posedge Clock) begin
		if (s1Advance) begin
			// Index zero-extended before the add
			s1Data.word  <= (seed.iv ^ MixKey) + IvWidth'(seed.bid);
			s1Data.iv    <= seed.iv;
			s1Data.bid   <= seed.bid;
			s1Data.write <= seed.write;
		end
	end

	// ----------------------------------------------------------------------
	// Stage two, rotate and fold back the IV
	// ----------------------------------------------------------------------

	assign rotWord = (s1Data.word << MixRotate) | (s1Data.word >> (IvWidth - MixRotate));

	always_ff @(posedge Clock) begin
		if (s2Advance) begin
			s2Data.pad   <= rotWord ^ s1Data.iv;
			s2Data.bid   <= s1Data.bid;
			s2Data.write <= s1Data.write;
		end
	end

	// Output straight from stage two
	assign pad      = s2Data;
	assign padValid = s2Valid;

endmodule

`default_nettype wire

// ==== hdl/pathSeedGen.sv ====
// Deterministic read/write pass sequencer for path eviction
// Path counter, shifted counter IV rule and bucket index per level

`default_nettype none

module pathSeedGen import oramPkg::*; (
	input  logic Clock,
	input  logic rstN,
	output seedT seed,
	output logic seedValid,
	input  logic seedReady
);

	// ----------------------------------------------------------------------
	// State and strobes
	// ----------------------------------------------------------------------

	// High for one cycle after reset, loads the first path
	logic                  startPulse;
	// 0 for the read pass, 1 for the write pass
	logic                  writePass;
	// Buckets transferred so far in this pass
	logic [LevelWidth-1:0] levelCnt;
	// Global path counter c
	logic [IvWidth-1:0]    pathCnt;
	logic [IvWidth-1:0]    pathCntNext;
	// c >> level for the current bucket
	logic [IvWidth-1:0]    ivShift;
	logic                  transfer;
	logic                  passDone;
	logic                  bidRestart;
	logic [BidWidth-1:0]   bucketIndex;

	assign transfer = seedValid && seedReady;

	// Last bucket of the pass leaves this cycle
	assign passDone = transfer && (levelCnt == LevelWidth'(OramLevels));

	// c moves on only once its write pass is done
	assign pathCntNext = pathCnt + IvWidth'(passDone && writePass);

	// Reload point for shifter and index walker
	assign bidRestart = startPulse || passDone;

	// ----------------------------------------------------------------------
	// Pass sequencing
	// ----------------------------------------------------------------------

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			startPulse <= 1'b1;
			// Read pass first
			writePass  <= 1'b0;
			levelCnt   <= '0;
			pathCnt    <= '0;
		end else begin
			startPulse <= 1'b0;
			pathCnt    <= pathCntNext;
			if (passDone) begin
				writePass <= ~writePass;
				levelCnt  <= '0;
			end else if (transfer) begin
				levelCnt <= levelCnt + LevelWidth'(1);
			end
		end
	end

	// ----------------------------------------------------------------------
	// Shifted counter
	// ----------------------------------------------------------------------

	// Loaded with c at pass start, one shift per bucket
	// read IV is c >> l, write IV is (c >> l) + 1
	always_ff @(posedge Clock) begin
		if (bidRestart) begin
			ivShift <= pathCntNext;
		end else if (transfer) begin
			ivShift <= ivShift >> 1;
		end
	end

	// ----------------------------------------------------------------------
	// Bucket index
	// ----------------------------------------------------------------------

	// Leaf is the low bits of the counter for the coming pass
	bucketIndexGen bidGen (
		.Clock       (Clock),
		.rstN        (rstN),
		.restart     (bidRestart),
		.leaf        (pathCntNext[OramLevels-1:0]),
		.advance     (transfer),
		.bucketIndex (bucketIndex)
	);

	// ----------------------------------------------------------------------
	// Output
	// ----------------------------------------------------------------------

	// Always something to offer once started
	assign seedValid = !startPulse;

	// All fields come from state, so they hold under back-pressure
	always_comb begin
		seed.iv    = ivShift + IvWidth'(writePass);
		seed.bid   = bucketIndex;
		seed.write = writePass;
	end

endmodule

`default_nettype wire

// ==== hdl/pathSeedTop.sv ====
// Path seed chain top level
// Generator, seed FIFO, pad mixer and pad FIFO in a line

`default_nettype none

module pathSeedTop import oramPkg::*; (
	input  logic Clock,
	input  logic rstN,
	output padT  pad,
	output logic padValid,
	input  logic padReady
);

	// ----------------------------------------------------------------------
	// Inter-block links
	// ----------------------------------------------------------------------

	// Generator to seed FIFO
	seedT genSeed;
	logic genValid;
	logic genReady;

	// Seed FIFO to mixer
	seedT bufSeed;
	logic bufValid;
	logic bufReady;

	// Mixer to pad FIFO
	padT  mixPad;
	logic mixValid;
	logic mixReady;

	// ----------------------------------------------------------------------
	// Chain
	// ----------------------------------------------------------------------

	pathSeedGen seedGen (
		.Clock     (Clock),
		.rstN      (rstN),
		.seed      (genSeed),
		.seedValid (genValid),
		.seedReady (genReady)
	);

	// Absorbs mixer stalls
	seedFifo #(
		.payloadT (seedT),
		.Depth    (FifoDepth)
	) seedBuf (
		.Clock    (Clock),
		.rstN     (rstN),
		.inData   (genSeed),
		.inValid  (genValid),
		.inReady  (genReady),
		.outData  (bufSeed),
		.outValid (bufValid),
		.outReady (bufReady)
	);

	padMixer mixer (
		.Clock     (Clock),
		.rstN      (rstN),
		.seed      (bufSeed),
		.seedValid (bufValid),
		.seedReady (bufReady),
		.pad       (mixPad),
		.padValid  (mixValid),
		.padReady  (mixReady)
	);

	// Decouples the mixer from the external sink
	seedFifo #(
		.payloadT (padT),
		.Depth    (FifoDepth)
	) padBuf (
		.Clock    (Clock),
		.rstN     (rstN),
		.inData   (mixPad),
		.inValid  (mixValid),
		.inReady  (mixReady),
		.outData  (pad),
		.outValid (padValid),
		.outReady (padReady)
	);

endmodule

`default_nettype wire

// ==== hdl/seedFifo.sv ====
// Small valid/ready FIFO with a type parameter for the payload
// Circular buffer with read/write pointers and an occupancy count

`default_nettype none

module seedFifo import oramPkg::*; #(
	parameter type payloadT = seedT,
	parameter int  Depth    = FifoDepth
) (
	input  logic    Clock,
	input  logic    rstN,
	input  payloadT inData,
	input  logic    inValid,
	output logic    inReady,
	output payloadT outData,
	output logic    outValid,
	input  logic    outReady
);

	localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
	localparam int CntWidth = $clog2(Depth + 1);

	// Storage, no reset needed
	payloadT mem [Depth];

	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic [CntWidth-1:0] count;
	logic                doWrite;
	logic                doRead;

	// Full blocks the writer even if a read happens this cycle
	assign inReady  = (count != CntWidth'(Depth));
	assign outValid = (count != '0);
	assign outData  = mem[rdPtr];

	assign doWrite = inValid && inReady;
	assign doRead  = outValid && outReady;

	// ----------------------------------------------------------------------
	// Data path
	// ----------------------------------------------------------------------

	always_ff @(posedge Clock) begin
		if (doWrite) begin
			mem[wrPtr] <= inData;
		end
	end

	// ----------------------------------------------------------------------
	// Pointers and count
	// ----------------------------------------------------------------------

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doWrite) begin
				// Wrap works for any depth
				wrPtr <= (wrPtr == PtrWidth'(Depth - 1)) ? '0 : wrPtr + PtrWidth'(1);
			end
			if (doRead) begin
				rdPtr <= (rdPtr == PtrWidth'(Depth - 1)) ? '0 : rdPtr + PtrWidth'(1);
			end
			// Simultaneous read and write leaves count unchanged
			count <= count + CntWidth'(doWrite) - CntWidth'(doRead);
		end
	end

endmodule

`default_nettype wire

// ==== src.f ====
hdl/oramPkg.sv
hdl/bucketIndexGen.sv
hdl/pathSeedGen.sv
hdl/seedFifo.sv
hdl/padMixer.sv
hdl/pathSeedTop.sv
dv/pathSeed_chk.sv
dv/pathSeedTb.sv
